// File: Makefile
# Verilator build and run for the USB sniffer testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_sniffer
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation finished without failure"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_usb_sniffer.sv
/*
 * Testbench for the USB sniffer capture path
 * UTMI packet stimulus, log word scoreboard, timeout and result line
 */
`timescale 1ns/1ps

module tb_usb_sniffer;
    import usb_sniffer_pkg::*;

    localparam int          FIFO_DEPTH = 4;
    localparam logic [31:0] BUF_BASE   = 32'h0000_1000;
    localparam logic [31:0] BUF_END    = 32'h0000_101C;

    // Compare masks with the cycle fields cleared
    localparam log_word_t SOF_MASK  = 32'hF800_07FF;
    localparam log_word_t CTRL_MASK = 32'hF00F_FFFF;
    localparam log_word_t FULL_MASK = 32'hFFFF_FFFF;

    typedef logic [7:0] byte_q_t [$];

    logic       clk;
    logic       rst;
    utmi_rx_t   utmi_rx;
    sniff_cfg_t cfg;
    mem_req_t   mem;
    logic       mem_stall;
    logic       wrapped;

    // Scoreboard state
    log_word_t   exp_word_q [$];
    log_word_t   exp_mask_q [$];
    logic [31:0] exp_addr;
    logic        exp_wrapped;
    logic [15:0] last_token;

    int     mismatch_cnt = 0;
    int     extra_cnt    = 0;
    int     cycle_cnt    = 0;
    int     pkt_cnt      = 0;
    bit     stall_en     = 1'b0;
    bit     timed_out    = 1'b0;
    integer seed;
    integer stall_seed;

    usb_sniffer_top
    #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .BUF_BASE   (BUF_BASE),
        .BUF_END    (BUF_END)
    )
    dut0
    (
        .clk_i       (clk),
        .rst_i       (rst),
        .utmi_rx_i   (utmi_rx),
        .cfg_i       (cfg),
        .mem_o       (mem),
        .mem_stall_i (mem_stall),
        .wrapped_o   (wrapped)
    );

    // --------------------
    // Clock and stall
    // --------------------
    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // Random memory stall on about one cycle in four
    initial
    begin
        forever
        begin
            @(posedge clk);
            #2;
            mem_stall = stall_en && (($unsigned($random(stall_seed)) % 4) == 0);
        end
    end

    // --------------------
    // Expected records
    // --------------------
    function automatic log_word_t record(logic [3:0] kind, logic [7:0] pid,
                                         logic [15:0] field);
        log_word_t w;
        w        = '0;
        w[31:28] = kind;
        w[19:4]  = field;
        w[3:0]   = pid[3:0];
        return w;
    endfunction

    // Match or exclude on device and endpoint of a token
    function automatic bit filter_ok(logic [15:0] token);
        bit dev_ok;
        bit ep_ok;
        dev_ok = 1'b1;
        ep_ok  = 1'b1;
        if (cfg.match_dev)
            dev_ok = (token[6:0] == cfg.dev);
        else if (cfg.exclude_dev)
            dev_ok = (token[6:0] != cfg.dev);
        if (cfg.match_ep)
            ep_ok = (token[10:7] == cfg.ep);
        else if (cfg.exclude_ep)
            ep_ok = (token[10:7] != cfg.ep);
        return dev_ok && ep_ok;
    endfunction

    task automatic expect_word(input log_word_t word, input log_word_t mask);
        exp_word_q.push_back(word);
        exp_mask_q.push_back(mask);
    endtask

    // --------------------
    // UTMI stimulus
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Bytes with random rxvalid gaps and then EOP
    task automatic send_packet(input byte_q_t bytes);
        int gap;
        pkt_cnt = pkt_cnt + 1;
        next_cycle();
        utmi_rx.rxactive = 1'b1;
        foreach (bytes[i])
        begin
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap)
                next_cycle();
            utmi_rx.data    = bytes[i];
            utmi_rx.rxvalid = 1'b1;
            next_cycle();
            utmi_rx.rxvalid = 1'b0;
        end
        next_cycle();
        utmi_rx.rxactive = 1'b0;
        repeat (3)
            next_cycle();
    endtask

    // Every expected word written before moving on
    task automatic wait_drain();
        while (exp_word_q.size() != 0)
            @(negedge clk);
        next_cycle();
    endtask

    task automatic send_sof(input logic [7:0] b2, input logic [7:0] b3);
        log_word_t w;
        byte_q_t   pkt;
        w        = '0;
        w[31:28] = 4'd1;
        // Frame number over byte 2 and low bits of byte 3
        w[10:0]  = {b3[2:0], b2};
        if (cfg.enabled && !cfg.ignore_sof)
            expect_word(w, SOF_MASK);
        pkt.push_back(PID_SOF);
        pkt.push_back(b2);
        pkt.push_back(b3);
        send_packet(pkt);
        wait_drain();
    endtask

    task automatic send_token(input logic [7:0] pid, input logic [6:0] dev,
                              input logic [3:0] ep);
        logic [7:0] b2;
        logic [7:0] b3;
        byte_q_t    pkt;
        b2 = {ep[0], dev};
        // Fixed CRC5 bits above the endpoint
        b3 = {5'b10110, ep[3:1]};
        last_token = {b3, b2};
        if (cfg.enabled && filter_ok(last_token))
            expect_word(record(4'd3, pid, last_token), CTRL_MASK);
        pkt.push_back(pid);
        pkt.push_back(b2);
        pkt.push_back(b3);
        send_packet(pkt);
        wait_drain();
    endtask

    task automatic send_data(input logic [7:0] pid, input int n);
        byte_q_t   pkt;
        log_word_t w;
        bit        log_it;
        log_it = cfg.enabled && filter_ok(last_token);
        pkt.push_back(pid);
        w = '0;
        for (int i = 0; i < n; i++)
        begin
            pkt.push_back(8'($random(seed)));
            // Little-endian lanes of four bytes per word
            w[8*(i%4) +: 8] = pkt[i+1];
            if ((i % 4 == 3) || (i == n - 1))
            begin
                if (log_it)
                    expect_word(w, FULL_MASK);
                w = '0;
            end
        end
        if (log_it)
            expect_word(record(4'd5, pid, 16'(n)), CTRL_MASK);
        send_packet(pkt);
        wait_drain();
    endtask

    task automatic send_hshake(input logic [7:0] pid);
        byte_q_t pkt;
        if (cfg.enabled && filter_ok(last_token))
            expect_word(record(4'd4, pid, 16'd0), CTRL_MASK);
        pkt.push_back(pid);
        send_packet(pkt);
        wait_drain();
    endtask

    // --------------------
    // Scoreboard
    // --------------------
    task automatic check_write();
        log_word_t w;
        log_word_t m;
        assert (exp_word_q.size() != 0)
        else
        begin
            $display("Unexpected memory write of %h at address %h at %0t, no log word pending",
                     mem.data, mem.addr, $time);
            extra_cnt = extra_cnt + 1;
        end
        if (exp_word_q.size() != 0)
        begin
            w = exp_word_q.pop_front();
            m = exp_mask_q.pop_front();
            assert ((mem.data & m) == (w & m))
            else
            begin
                $display("Fail at %0t: log word %h, expected %h (mask %h)",
                         $time, mem.data, w, m);
                mismatch_cnt = mismatch_cnt + 1;
            end
            assert (mem.addr == exp_addr)
            else
            begin
                $display("Fail at %0t: write address %h, expected %h",
                         $time, mem.addr, exp_addr);
                mismatch_cnt = mismatch_cnt + 1;
            end
        end
        // Ring step after each accepted write
        if (exp_addr == BUF_END)
        begin
            exp_addr    = BUF_BASE;
            exp_wrapped = 1'b1;
        end
        else
            exp_addr = exp_addr + 32'd4;
    endtask

    // Outputs settle mid-cycle and are accepted at the next rising edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            assert (wrapped == exp_wrapped)
            else
            begin
                $display("Fail at %0t: wrapped flag %0b, expected %0b",
                         $time, wrapped, exp_wrapped);
                mismatch_cnt = mismatch_cnt + 1;
            end
            if (mem.stb && !mem_stall)
                check_write();
        end
    end

    task automatic finish_run();
        int prop_cnt;
        int missing;
        prop_cnt = int'(dut0.u_props.fail_count);
        missing  = exp_word_q.size();
        if (missing != 0)
            $display("%0d expected log words never reached memory", missing);
        $display("Errors: %0d mismatch, %0d extra, %0d missing, %0d property, %0d timeout",
                 mismatch_cnt, extra_cnt, missing, prop_cnt, int'(timed_out));
        if (mismatch_cnt + extra_cnt + missing + prop_cnt == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    // Limit grows with the packets sent
    initial
    begin
        wait (cycle_cnt > 200 * pkt_cnt + 500);
        timed_out = 1'b1;
        $display("Timeout after %0d cycles, the log did not drain", cycle_cnt);
        finish_run();
    end

    // --------------------
    // Test sequence
    // --------------------
    initial
    begin
        seed            = 32'h9a68fb8a;
        stall_seed      = ~seed;
        rst             = 1'b1;
        utmi_rx         = '0;
        cfg             = '0;
        cfg.enabled     = 1'b1;
        mem_stall       = 1'b0;
        exp_addr        = BUF_BASE;
        exp_wrapped     = 1'b0;
        last_token      = '0;
        repeat (10)
            @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3)
            next_cycle();

        // Plain records while the ring wraps
        send_sof(8'h37, 8'hAD);
        send_token(PID_OUT, 7'd5, 4'd2);
        send_data(PID_DATA0, 7);
        send_hshake(PID_ACK);
        send_token(PID_IN, 7'd5, 4'd2);
        send_data(PID_DATA1, 5);
        send_hshake(PID_ACK);
        send_token(PID_SETUP, 7'd5, 4'd0);
        send_data(PID_DATA0, 8);
        send_hshake(PID_NAK);

        // SOF suppressed
        cfg.ignore_sof = 1'b1;
        send_sof(8'h38, 8'hAD);
        cfg.ignore_sof = 1'b0;

        // Match on device 9
        cfg.dev       = 7'd9;
        cfg.match_dev = 1'b1;
        send_token(PID_OUT, 7'd5, 4'd1);
        send_data(PID_DATA0, 3);
        send_hshake(PID_ACK);
        send_token(PID_OUT, 7'd9, 4'd1);
        send_hshake(PID_ACK);

        // Exclude device 9
        cfg.match_dev   = 1'b0;
        cfg.exclude_dev = 1'b1;
        send_token(PID_IN, 7'd9, 4'd3);
        send_data(PID_DATA1, 2);
        send_hshake(PID_ACK);
        send_token(PID_IN, 7'd5, 4'd3);
        send_data(PID_DATA1, 2);
        send_hshake(PID_ACK);
        cfg.exclude_dev = 1'b0;

        // Random payloads under memory stall
        stall_en = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            send_token(PID_OUT, 7'd5, 4'(i));
            send_data(i[0] ? PID_DATA1 : PID_DATA0,
                      1 + int'($unsigned($random(seed)) % 12));
            send_hshake(PID_ACK);
        end
        stall_en = 1'b0;

        repeat (20)
            next_cycle();
        finish_run();
    end

endmodule

// File: dv/usb_sniffer_properties.sv
/*
 * Concurrent checks on the memory port of the sniffer top level
 */
`timescale 1ns/1ps

module usb_sniffer_properties
#(
    parameter logic [31:0] BUF_BASE = 32'h0000_1000,
    parameter logic [31:0] BUF_END  = 32'h0000_1FFC
)
(
    input logic                      clk_i,
    input logic                      rst_i,
    input usb_sniffer_pkg::mem_req_t mem_i,
    input logic                      mem_stall_i
);

    // Number of failed properties so far
    int unsigned fail_count = 0;

    // --------------------
    // Memory request
    // --------------------
    // Stalled request holds strobe, address and data
    property p_hold_on_stall;
        @(posedge clk_i) disable iff (rst_i)
        (mem_i.stb && mem_stall_i) |=>
            (mem_i.stb && $stable(mem_i.addr) && $stable(mem_i.data));
    endproperty

    // Address inside the ring, word aligned
    property p_addr_in_ring;
        @(posedge clk_i) disable iff (rst_i)
        mem_i.stb |->
            ((mem_i.addr >= BUF_BASE) && (mem_i.addr <= BUF_END) && (mem_i.addr[1:0] == 2'b00));
    endproperty

    // No strobe while reset is held
    property p_idle_in_reset;
        @(posedge clk_i) rst_i |-> !mem_i.stb;
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
    else
    begin
        fail_count++;
        $error("memory request changed while the memory stalled it");
    end

    a_addr_in_ring: assert property (p_addr_in_ring)
    else
    begin
        fail_count++;
        $error("write address %h outside the ring or not word aligned", mem_i.addr);
    end

    a_idle_in_reset: assert property (p_idle_in_reset)
    else
    begin
        fail_count++;
        $error("memory strobe high during reset");
    end

endmodule

bind usb_sniffer_top usb_sniffer_properties
#(
    .BUF_BASE (BUF_BASE),
    .BUF_END  (BUF_END)
)
u_props
(
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_i       (mem_o),
    .mem_stall_i (mem_stall_i)
);

// File: source/log_fifo.sv
/*
 * Circular FIFO of log words between decoder and memory writer
 */
`timescale 1ns/1ps

module log_fifo
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      push_i,
    input  usb_sniffer_pkg::log_word_t push_word_i,
    output logic                      full_o,
    input  logic                      pop_i,
    output logic                      pop_valid_o,
    output usb_sniffer_pkg::log_word_t pop_word_o
);
    import usb_sniffer_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    log_word_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    wire wr_en = push_i && !full_o;
    wire rd_en = pop_i && pop_valid_o;

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (wr_en)
            mem_q[wr_ptr_q] <= push_word_i;
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            // Pointers wrap at depth, which need not be a power of two
            if (wr_en)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign full_o      = (count_q == CNT_W'(FIFO_DEPTH));
    assign pop_valid_o = (count_q != '0);
    assign pop_word_o  = mem_q[rd_ptr_q];

endmodule

// File: source/log_mem_writer.sv
/*
 * Write-only memory master storing log words in a circular buffer
 */
`timescale 1ns/1ps

module log_mem_writer
#(
    parameter logic [31:0] BUF_BASE = 32'h0000_1000,
    parameter logic [31:0] BUF_END  = 32'h0000_1FFC
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      pop_valid_i,
    input  usb_sniffer_pkg::log_word_t pop_word_i,
    output logic                      pop_o,
    output usb_sniffer_pkg::mem_req_t  mem_o,
    input  logic                      mem_stall_i,
    output logic                      wrapped_o
);
    import usb_sniffer_pkg::*;

    logic        stb_q;
    log_word_t   data_q;
    logic [31:0] addr_q;
    logic        wrapped_q;

    // Slot free when empty or being accepted now
    wire slot_free = !stb_q || !mem_stall_i;
    wire accept    = stb_q && !mem_stall_i;

    assign pop_o = pop_valid_i && slot_free;

    // --------------------
    // Pending request
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            stb_q <= 1'b0;
        else if (slot_free)
            stb_q <= pop_valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (pop_o)
            data_q <= pop_word_i;
    end

    // --------------------
    // Ring address
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            addr_q    <= BUF_BASE;
            wrapped_q <= 1'b0;
        end
        else if (accept)
        begin
            if (addr_q == BUF_END)
            begin
                addr_q    <= BUF_BASE;
                // Sticky once the ring has been filled
                wrapped_q <= 1'b1;
            end
            else
                addr_q <= addr_q + 32'd4;
        end
    end

    assign mem_o     = '{addr: addr_q, data: data_q, stb: stb_q};
    assign wrapped_o = wrapped_q;

endmodule

// File: source/usb_packet_logger.sv
/*
 * Packet decoder for the UTMI receive side
 * Turns SOF, token, handshake and data packets into log words
 */
`timescale 1ns/1ps

module usb_packet_logger
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  usb_sniffer_pkg::utmi_rx_t   utmi_rx_i,
    input  usb_sniffer_pkg::sniff_cfg_t cfg_i,
    input  logic                       fifo_full_i,
    output logic                       log_push_o,
    output usb_sniffer_pkg::log_word_t  log_word_o
);
    import usb_sniffer_pkg::*;

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_TOKEN2,
        ST_TOKEN3,
        ST_TOKEN_DONE,
        ST_SOF2,
        ST_SOF3,
        ST_SOF_DONE,
        ST_DATA,
        ST_DATA_DONE,
        ST_HSHAKE_DONE,
        ST_IGNORE
    } state_e;

    state_e      state_q;
    state_e      next_state;
    logic        active_q;
    logic [7:0]  pid_q;
    logic [10:0] frame_q;
    logic [15:0] token_q;
    logic [15:0] cycle_q;
    logic [15:0] data_cnt_q;
    log_word_t   word_q;
    logic        word_rdy_q;
    logic        dev_ok;
    logic        ep_ok;
    logic        push;

    // --------------------
    // Packet activity
    // --------------------
    wire sample_byte  = utmi_rx_i.rxvalid && utmi_rx_i.rxactive;
    wire start_packet = !active_q && sample_byte && cfg_i.enabled;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            active_q <= 1'b0;
        else if (start_packet)
            active_q <= 1'b1;
        else if (!utmi_rx_i.rxactive)
            active_q <= 1'b0;
    end

    // Device and endpoint filter on the last token
    always_comb
    begin
        if (cfg_i.match_dev)
            dev_ok = (token_q[6:0] == cfg_i.dev);
        else if (cfg_i.exclude_dev)
            dev_ok = (token_q[6:0] != cfg_i.dev);
        else
            dev_ok = 1'b1;

        if (cfg_i.match_ep)
            ep_ok = (token_q[10:7] == cfg_i.ep);
        else if (cfg_i.exclude_ep)
            ep_ok = (token_q[10:7] != cfg_i.ep);
        else
            ep_ok = 1'b1;
    end

    // --------------------
    // Receive FSM
    // --------------------
    always_comb
    begin
        next_state = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (start_packet)
                begin
                    case (utmi_rx_i.data)
                        PID_OUT, PID_IN, PID_SETUP, PID_PING:
                            next_state = ST_TOKEN2;
                        PID_SOF:
                            next_state = ST_SOF2;
                        PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA:
                            next_state = (dev_ok && ep_ok) ? ST_DATA : ST_IGNORE;
                        PID_ACK, PID_NAK, PID_STALL, PID_NYET:
                            next_state = (dev_ok && ep_ok) ? ST_HSHAKE_DONE : ST_IGNORE;
                        // PRE, SPLIT and unknown PIDs
                        default:
                            next_state = ST_IGNORE;
                    endcase
                    // No room, skip the whole packet
                    if (fifo_full_i)
                        next_state = ST_IGNORE;
                end
            end
            ST_TOKEN2, ST_TOKEN3, ST_SOF2, ST_SOF3:
            begin
                if (sample_byte)
                    next_state = state_e'(state_q + 4'd1);
                else if (!utmi_rx_i.rxactive)
                    next_state = ST_IDLE;
            end
            ST_DATA:
            begin
                // Full FIFO abandons the packet
                if (fifo_full_i)
                    next_state = ST_IGNORE;
                else if (!utmi_rx_i.rxactive)
                    next_state = ST_DATA_DONE;
            end
            ST_IGNORE:
            begin
                if (!utmi_rx_i.rxactive)
                    next_state = ST_IDLE;
            end
            // Completion states last one cycle
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= ST_IDLE;
        else
            state_q <= next_state;
    end

    // --------------------
    // Captured fields
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pid_q   <= 8'h00;
            frame_q <= 11'd0;
            token_q <= 16'd0;
        end
        else
        begin
            if (start_packet && state_q == ST_IDLE)
                pid_q <= utmi_rx_i.data;
            // Frame number is 11 bits over bytes 2 and 3
            if (state_q == ST_SOF2 && sample_byte)
                frame_q[7:0] <= utmi_rx_i.data;
            if (state_q == ST_SOF3 && sample_byte)
                frame_q[10:8] <= utmi_rx_i.data[2:0];
            if (state_q == ST_TOKEN2 && sample_byte)
                token_q[7:0] <= utmi_rx_i.data;
            if (state_q == ST_TOKEN3 && sample_byte)
                token_q[15:8] <= utmi_rx_i.data;
        end
    end

    // Cycles since last SOF, saturating
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            cycle_q <= 16'd0;
        else if (state_q == ST_SOF_DONE)
            cycle_q <= 16'd0;
        else if (cycle_q != 16'hFFFF)
            cycle_q <= cycle_q + 16'd1;
    end

    // Data byte count and full word flag
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            data_cnt_q <= 16'd0;
            word_rdy_q <= 1'b0;
        end
        else
        begin
            word_rdy_q <= (state_q == ST_DATA) && sample_byte && (data_cnt_q[1:0] == 2'd3);
            if (state_q == ST_IDLE)
                data_cnt_q <= 16'd0;
            else if (state_q == ST_DATA && sample_byte)
                data_cnt_q <= data_cnt_q + 16'd1;
        end
    end

    // Payload bytes packed little-endian
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_DATA && sample_byte)
        begin
            case (data_cnt_q[1:0])
                2'd0:    word_q <= {24'd0, utmi_rx_i.data};
                2'd1:    word_q <= {16'd0, utmi_rx_i.data, word_q[7:0]};
                2'd2:    word_q <= {8'd0, utmi_rx_i.data, word_q[15:0]};
                default: word_q <= {utmi_rx_i.data, word_q[23:0]};
            endcase
        end
    end

    // --------------------
    // Log record
    // --------------------
    always_comb
    begin
        log_word_o = '0;
        push       = 1'b0;
        case (state_q)
            ST_SOF_DONE:
            begin
                log_word_o[LOG_SOF_FRAME_H:LOG_SOF_FRAME_L] = frame_q;
                log_word_o[LOG_SOF_CYCLE_H:LOG_SOF_CYCLE_L] = cycle_q;
                log_word_o[LOG_TYPE_H:LOG_TYPE_L]           = LOG_SOF;
                push = !cfg_i.ignore_sof;
            end
            ST_TOKEN_DONE:
            begin
                log_word_o[LOG_PID_H:LOG_PID_L]               = pid_q[3:0];
                log_word_o[LOG_DATA_H:LOG_DATA_L]             = token_q;
                log_word_o[LOG_CTRL_CYCLE_H:LOG_CTRL_CYCLE_L] = cycle_q[15:8];
                log_word_o[LOG_TYPE_H:LOG_TYPE_L]             = LOG_TOKEN;
                push = dev_ok && ep_ok;
            end
            ST_HSHAKE_DONE:
            begin
                log_word_o[LOG_PID_H:LOG_PID_L]               = pid_q[3:0];
                log_word_o[LOG_CTRL_CYCLE_H:LOG_CTRL_CYCLE_L] = cycle_q[15:8];
                log_word_o[LOG_TYPE_H:LOG_TYPE_L]             = LOG_HSHAKE;
                push = 1'b1;
            end
            ST_DATA_DONE:
            begin
                log_word_o[LOG_PID_H:LOG_PID_L]               = pid_q[3:0];
                log_word_o[LOG_DATA_H:LOG_DATA_L]             = data_cnt_q;
                log_word_o[LOG_CTRL_CYCLE_H:LOG_CTRL_CYCLE_L] = cycle_q[15:8];
                log_word_o[LOG_TYPE_H:LOG_TYPE_L]             = LOG_DATA;
                push = 1'b1;
            end
            ST_DATA:
            begin
                // Full word, or partial word as rxactive drops
                log_word_o = word_q;
                push = word_rdy_q || (!utmi_rx_i.rxactive && data_cnt_q[1:0] != 2'd0);
            end
            default:
                push = 1'b0;
        endcase
    end

    // Record lost when the FIFO has no room
    assign log_push_o = push && !fifo_full_i;

endmodule

// File: source/usb_sniffer_pkg.sv
/*
 * Shared definitions for the USB sniffer capture path
 * Log word layout, record types, PID values, UTMI, config and memory structs
 */
package usb_sniffer_pkg;

    // --------------------
    // Log word format
    // --------------------
    // Formats overlap, so the word stays a plain vector
    typedef logic [31:0] log_word_t;

    // Record type in bits 31:28
    typedef enum logic [3:0]
    {
        LOG_SOF    = 4'd1,
        LOG_TOKEN  = 4'd3,
        LOG_HSHAKE = 4'd4,
        LOG_DATA   = 4'd5
    } log_type_e;

    // SOF record
    localparam int LOG_SOF_FRAME_L  = 0;
    localparam int LOG_SOF_FRAME_H  = 10;
    localparam int LOG_SOF_CYCLE_L  = 11;
    localparam int LOG_SOF_CYCLE_H  = 26;

    // Token, handshake and data records
    localparam int LOG_PID_L        = 0;
    localparam int LOG_PID_H        = 3;
    // Token data or data length
    localparam int LOG_DATA_L       = 4;
    localparam int LOG_DATA_H       = 19;
    localparam int LOG_CTRL_CYCLE_L = 20;
    localparam int LOG_CTRL_CYCLE_H = 27;

    localparam int LOG_TYPE_L       = 28;
    localparam int LOG_TYPE_H       = 31;

    // --------------------
    // USB PIDs
    // --------------------
    // Tokens
    localparam logic [7:0] PID_OUT   = 8'hE1;
    localparam logic [7:0] PID_IN    = 8'h69;
    localparam logic [7:0] PID_SETUP = 8'h2D;
    localparam logic [7:0] PID_PING  = 8'hB4;
    localparam logic [7:0] PID_SOF   = 8'hA5;

    // Data
    localparam logic [7:0] PID_DATA0 = 8'hC3;
    localparam logic [7:0] PID_DATA1 = 8'h4B;
    localparam logic [7:0] PID_DATA2 = 8'h87;
    localparam logic [7:0] PID_MDATA = 8'h0F;

    // Handshake
    localparam logic [7:0] PID_ACK   = 8'hD2;
    localparam logic [7:0] PID_NAK   = 8'h5A;
    localparam logic [7:0] PID_STALL = 8'h1E;
    localparam logic [7:0] PID_NYET  = 8'h96;

    // Special, never logged
    localparam logic [7:0] PID_PRE   = 8'h3C;
    localparam logic [7:0] PID_SPLIT = 8'h78;

    // --------------------
    // Bus structs
    // --------------------
    // UTMI receive side
    typedef struct packed
    {
        logic [7:0] data;
        logic       rxvalid;
        logic       rxactive;
    } utmi_rx_t;

    // Static capture configuration
    typedef struct packed
    {
        logic       enabled;
        logic       ignore_sof;
        logic       match_dev;
        logic       exclude_dev;
        logic [6:0] dev;
        logic       match_ep;
        logic       exclude_ep;
        logic [3:0] ep;
    } sniff_cfg_t;

    // Write-only memory request, byte select and write enable implied
    typedef struct packed
    {
        logic [31:0] addr;
        logic [31:0] data;
        logic        stb;
    } mem_req_t;

endpackage

// File: source/usb_sniffer_top.sv
/*
 * USB sniffer capture path: decoder, log FIFO and memory writer
 */
`timescale 1ns/1ps

module usb_sniffer_top
#(
    parameter int          FIFO_DEPTH = 4,
    parameter logic [31:0] BUF_BASE   = 32'h0000_1000,
    parameter logic [31:0] BUF_END    = 32'h0000_1FFC
)
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  usb_sniffer_pkg::utmi_rx_t   utmi_rx_i,
    input  usb_sniffer_pkg::sniff_cfg_t cfg_i,
    output usb_sniffer_pkg::mem_req_t   mem_o,
    input  logic                       mem_stall_i,
    output logic                       wrapped_o
);
    import usb_sniffer_pkg::*;

    // Decoder to FIFO
    logic      log_push;
    log_word_t log_word;
    logic      fifo_full;

    // FIFO to writer
    logic      pop_valid;
    log_word_t pop_word;
    logic      pop;

    usb_packet_logger u_logger
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .utmi_rx_i   (utmi_rx_i),
        .cfg_i       (cfg_i),
        .fifo_full_i (fifo_full),
        .log_push_o  (log_push),
        .log_word_o  (log_word)
    );

    log_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (log_push),
        .push_word_i (log_word),
        .full_o      (fifo_full),
        .pop_i       (pop),
        .pop_valid_o (pop_valid),
        .pop_word_o  (pop_word)
    );

    log_mem_writer #(.BUF_BASE(BUF_BASE), .BUF_END(BUF_END)) u_writer
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pop_valid_i (pop_valid),
        .pop_word_i  (pop_word),
        .pop_o       (pop),
        .mem_o       (mem_o),
        .mem_stall_i (mem_stall_i),
        .wrapped_o   (wrapped_o)
    );

endmodule

// File: tb.f
source/usb_sniffer_pkg.sv
source/usb_packet_logger.sv
source/log_fifo.sv
source/log_mem_writer.sv
source/usb_sniffer_top.sv
dv/usb_sniffer_properties.sv
dv/tb_usb_sniffer.sv
